//--- flist.f
+incdir+rtl
+incdir+tests
rtl/periph_pkg.sv
rtl/rng_lfsr.sv
rtl/rng_fifo.sv
rtl/gpio_regs.sv
rtl/periph_top.sv
tests/tb_periph.sv

//--- rtl/gpio_regs.sv
// Read data is valid the cycle after the request; pop and clear strobes fire the cycle after a write
`timescale 1ns/1ps
`include "periph_macros.svh"

module gpio_regs (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  periph_pkg::mem_req_t      req_i,
    output logic [`PERIPH_DATA_W-1:0] rdata_o,
    output logic [`LED_W-1:0]         leds_o,
    input  logic [`LED_W-1:0]         dip_switches_i,
    output logic                      rng_en_o,
    output logic                      pop_o,
    output logic                      err_clr_o,
    input  logic [`PERIPH_DATA_W-1:0] head_i,
    input  periph_pkg::rng_status_t   status_i
);

    periph_pkg::reg_sel_e sel;       // Select of the current request
    periph_pkg::reg_sel_e sel_q;     // Select of the previous access
    logic                 wr_en;

    logic [`PERIPH_DATA_W-1:0] status_word;

    assign sel   = periph_pkg::reg_sel_e'(req_i.addr[`REG_SEL_MSB:`REG_SEL_LSB]);
    assign wr_en = req_i.en && req_i.we;

    // ----------------------------------------
    // Write side
    // ----------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            leds_o    <= '0;
            rng_en_o  <= 1'b0;
            pop_o     <= 1'b0;
            err_clr_o <= 1'b0;
            sel_q     <= periph_pkg::REG_GPIO;
        end
        else
        begin
            // Strobes last one cycle
            pop_o     <= 1'b0;
            err_clr_o <= 1'b0;

            if (req_i.en)
            begin
                sel_q <= sel;  // Steers the read mux next cycle
            end

            if (wr_en)
            begin
                case (sel)
                    periph_pkg::REG_GPIO:
                    begin
                        leds_o <= req_i.wdata[`LED_W-1:0];
                    end
                    periph_pkg::REG_RNG_DATA:
                    begin
                        pop_o <= 1'b1;  // Any write drops the head
                    end
                    periph_pkg::REG_RNG_CTRL:
                    begin
                        rng_en_o  <= req_i.wdata[`CTRL_EN_BIT];
                        err_clr_o <= req_i.wdata[`CTRL_CLR_BIT];
                    end
                    default:
                    begin
                        // Writes outside the map are dropped
                    end
                endcase
            end
        end
    end

    // ----------------------------------------
    // Read side
    // ----------------------------------------

    // Flags on top, count in the low bits
    assign status_word = {status_i.full,
                          status_i.empty,
                          status_i.rderr,
                          rng_en_o,
                          {(`PERIPH_DATA_W-4-`RNG_CNT_W){1'b0}},
                          status_i.count};

    always_comb
    begin
        case (sel_q)
            periph_pkg::REG_GPIO:
                rdata_o = {{(`PERIPH_DATA_W-`LED_W){1'b0}}, dip_switches_i};
            periph_pkg::REG_RNG_DATA:
                rdata_o = head_i;  // Current head, not the popped word
            periph_pkg::REG_RNG_CTRL:
                rdata_o = status_word;
            default:
                rdata_o = `UNMAPPED_RDATA;
        endcase
    end

endmodule

//--- rtl/periph_macros.svh
// Widths and register map are fixed at compile time; the LFSR seed must never be zero
`ifndef PERIPH_MACROS_SVH
`define PERIPH_MACROS_SVH

// ----------------------------------------
// Bus widths
// ----------------------------------------
`define PERIPH_DATA_W   32
`define PERIPH_ADDR_W   16

// Address slice that picks one register
`define REG_SEL_LSB     3
`define REG_SEL_MSB     5

// Register indices within the window
`define REG_IDX_GPIO     3'd0
`define REG_IDX_RNG_DATA 3'd2
`define REG_IDX_RNG_CTRL 3'd3

// Control register write bits
`define CTRL_EN_BIT     0
`define CTRL_CLR_BIT    1

// ----------------------------------------
// Random source and its FIFO
// ----------------------------------------
`define RNG_FIFO_DEPTH  16
`define RNG_CNT_W       5            // Holds 0 to 16
`define RNG_SEED        32'h1ACE_B00C
`define RNG_TAPS        32'h8020_0003 // x^32 + x^22 + x^2 + x + 1

// Returned for any select outside the map
`define UNMAPPED_RDATA  32'hDEAD_BEEF

`define LED_W           8

`endif

//--- rtl/periph_pkg.sv
// Types shared by the register window; widths follow the macros header
`include "periph_macros.svh"

package periph_pkg;

    // ----------------------------------------
    // Request port, one access per cycle with en high
    // ----------------------------------------
    typedef struct packed {
        logic                      en;
        logic                      we;
        logic [`PERIPH_ADDR_W-1:0] addr;
        logic [`PERIPH_DATA_W-1:0] wdata;
    } mem_req_t;

    // ----------------------------------------
    // FIFO state as seen by the generator and the registers
    // ----------------------------------------
    typedef struct packed {
        logic                  full;
        logic                  empty;
        logic                  rderr;  // Sticky, pop while empty
        logic [`RNG_CNT_W-1:0] count;
    } rng_status_t;

    // Register select, decoded from the address slice
    // Unlisted codes read back the fallback word
    typedef enum logic [2:0] {
        REG_GPIO     = `REG_IDX_GPIO,      // LEDs out, DIP switches in
        REG_RNG_DATA = `REG_IDX_RNG_DATA,  // FIFO head, write pops
        REG_RNG_CTRL = `REG_IDX_RNG_CTRL   // Status read, control write
    } reg_sel_e;

endpackage

//--- rtl/periph_top.sv
// Single register window with an LFSR-fed random FIFO; request port has no back-pressure
`timescale 1ns/1ps
`include "periph_macros.svh"

module periph_top (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  periph_pkg::mem_req_t      req_i,
    output logic [`PERIPH_DATA_W-1:0] rdata_o,
    output logic [`LED_W-1:0]         leds_o,
    input  logic [`LED_W-1:0]         dip_switches_i
);

    // ----------------------------------------
    // Internal links
    // ----------------------------------------
    logic                      rng_en;
    logic                      pop;
    logic                      err_clr;
    logic                      push;
    logic [`PERIPH_DATA_W-1:0] rng_data;   // Generator to FIFO
    logic [`PERIPH_DATA_W-1:0] fifo_head;  // FIFO to read mux
    periph_pkg::rng_status_t   fifo_status;

    gpio_regs i_gpio_regs (
        .clk_i          ( clk_i          ),
        .rst_i          ( rst_i          ),
        .req_i          ( req_i          ),
        .rdata_o        ( rdata_o        ),
        .leds_o         ( leds_o         ),
        .dip_switches_i ( dip_switches_i ),
        .rng_en_o       ( rng_en         ),
        .pop_o          ( pop            ),
        .err_clr_o      ( err_clr        ),
        .head_i         ( fifo_head      ),
        .status_i       ( fifo_status    )
    );

    // Generator pauses on its own when the FIFO is full
    rng_lfsr i_rng_lfsr (
        .clk_i    ( clk_i       ),
        .rst_i    ( rst_i       ),
        .en_i     ( rng_en      ),
        .status_i ( fifo_status ),
        .push_o   ( push        ),
        .data_o   ( rng_data    )
    );

    rng_fifo i_rng_fifo (
        .clk_i     ( clk_i       ),
        .rst_i     ( rst_i       ),
        .push_i    ( push        ),
        .data_i    ( rng_data    ),
        .pop_i     ( pop         ),
        .err_clr_i ( err_clr     ),
        .head_o    ( fifo_head   ),
        .status_o  ( fifo_status )
    );

endmodule

//--- rtl/rng_fifo.sv
// No full check on push, the writer must hold off when full; pop while empty only flags rderr
`timescale 1ns/1ps
`include "periph_macros.svh"

module rng_fifo (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      push_i,
    input  logic [`PERIPH_DATA_W-1:0] data_i,
    input  logic                      pop_i,
    input  logic                      err_clr_i,
    output logic [`PERIPH_DATA_W-1:0] head_o,
    output periph_pkg::rng_status_t   status_o
);

    // ----------------------------------------
    // Storage and pointers
    // ----------------------------------------
    logic [`PERIPH_DATA_W-1:0] mem [`RNG_FIFO_DEPTH];

    logic [`RNG_CNT_W-2:0] wr_ptr_q;  // Wraps at depth
    logic [`RNG_CNT_W-2:0] rd_ptr_q;
    logic [`RNG_CNT_W-1:0] count_q;
    logic                  rderr_q;

    logic full;
    logic empty;
    logic do_pop;

    assign full   = (count_q == `RNG_CNT_W'(`RNG_FIFO_DEPTH));
    assign empty  = (count_q == '0);
    assign do_pop = pop_i && !empty;

    // Data array, written on every push
    always_ff @(posedge clk_i)
    begin
        if (push_i)
        begin
            mem[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (push_i)
            begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // Push and pop together leave the count alone
            case ({push_i, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // ----------------------------------------
    // Sticky underflow flag
    // ----------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            rderr_q <= 1'b0;
        end
        else if (pop_i && empty)
        begin
            rderr_q <= 1'b1;  // A fresh underflow outranks a clear
        end
        else if (err_clr_i)
        begin
            rderr_q <= 1'b0;
        end
    end

    assign head_o = mem[rd_ptr_q];

    assign status_o.full  = full;
    assign status_o.empty = empty;
    assign status_o.rderr = rderr_q;
    assign status_o.count = count_q;

endmodule

//--- rtl/rng_lfsr.sv
// Steps only on a push, so the pushed words depend on the seed alone and not on timing
`timescale 1ns/1ps
`include "periph_macros.svh"

module rng_lfsr (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      en_i,      // Generation enable level
    input  periph_pkg::rng_status_t   status_i,  // From the FIFO
    output logic                      push_o,
    output logic [`PERIPH_DATA_W-1:0] data_o
);

    logic [`PERIPH_DATA_W-1:0] lfsr_q;
    logic [`PERIPH_DATA_W-1:0] lfsr_next;

    // ----------------------------------------
    // Galois step, shift right and fold in taps
    // ----------------------------------------
    always_comb
    begin
        lfsr_next = {1'b0, lfsr_q[`PERIPH_DATA_W-1:1]};
        if (lfsr_q[0])
        begin
            lfsr_next = lfsr_next ^ `RNG_TAPS;
        end
    end

    // Keep the FIFO topped up while enabled
    assign push_o = en_i && !status_i.full;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            lfsr_q <= `RNG_SEED;
        end
        else if (push_o)
        begin
            lfsr_q <= lfsr_next;  // Word just pushed is consumed
        end
    end

    assign data_o = lfsr_q;

endmodule

//--- tests/periph_model.svh
// Model state lives in the including module, which must include the macros header first
`ifndef PERIPH_MODEL_SVH
`define PERIPH_MODEL_SVH

// ----------------------------------------
// Model state
// ----------------------------------------
logic [`PERIPH_DATA_W-1:0] model_lfsr;  // Next word the FIFO should hand out
logic                      model_en;
logic [`LED_W-1:0]         model_leds;

task automatic model_reset();
    model_lfsr = `RNG_SEED;
    model_en   = 1'b0;
    model_leds = '0;
endtask

// Galois step shifts right and folds in the taps when a one drops out
function automatic logic [`PERIPH_DATA_W-1:0] lfsr_advance(input logic [`PERIPH_DATA_W-1:0] v);
    logic dropped;
    dropped = v[0];
    v = v >> 1;
    if (dropped)
    begin
        v = v ^ `RNG_TAPS;
    end
    return v;
endfunction

// Hands out the predicted word and moves on
task automatic take_word(output logic [`PERIPH_DATA_W-1:0] w);
    w          = model_lfsr;
    model_lfsr = lfsr_advance(model_lfsr);
endtask

// ----------------------------------------
// Register map
// ----------------------------------------
function automatic logic [`PERIPH_DATA_W-1:0] expected_status(input logic full,
    input logic empty, input logic rderr, input logic en, input logic [4:0] count);
    logic [`PERIPH_DATA_W-1:0] w;
    w      = '0;
    w[31]  = full;
    w[30]  = empty;
    w[29]  = rderr;
    w[28]  = en;    // Enable as last written
    w[4:0] = count;
    return w;
endfunction

// Covers the GPIO register and every unmapped select
function automatic logic [`PERIPH_DATA_W-1:0] fixed_read(input logic [2:0] sel,
    input logic [`LED_W-1:0] dip);
    if (sel == 3'd0)
    begin
        return 32'(dip);  // Switches read back zero-extended
    end
    return 32'hDEAD_BEEF;
endfunction

`endif

//--- tests/tb_periph.sv
// Drives the request port only and samples read data 1 ns into the cycle after each request
`timescale 1ns/1ps
`include "periph_macros.svh"

module tb_periph;

    localparam int CLK_PERIOD_NS    = 100;
    localparam int PLANNED_ACCESSES = 160;
    localparam int WATCHDOG_NS      = PLANNED_ACCESSES * 30 * CLK_PERIOD_NS;
    localparam int SETTLE_CYCLES    = 20;  // Long enough for a full refill
    localparam int WRITE_GAP        = 3;

    logic                      clk;
    logic                      rst;
    periph_pkg::mem_req_t      req;
    logic [`PERIPH_DATA_W-1:0] rdata;
    logic [`LED_W-1:0]         leds;
    logic [`LED_W-1:0]         dip;

    int error_count;
    int check_count;

    `include "periph_model.svh"

    periph_top i_dut (
        .clk_i          ( clk   ),
        .rst_i          ( rst   ),
        .req_i          ( req   ),
        .rdata_o        ( rdata ),
        .leds_o         ( leds  ),
        .dip_switches_i ( dip   )
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk = ~clk;
    end

    // Watchdog
    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, the test sequence did not complete", WATCHDOG_NS);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        $display("TEST FAIL");
        $finish;
    end

    // ----------------------------------------
    // Bus helpers, called 1 ns after an edge
    // ----------------------------------------
    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    // Random address bits outside the select slice
    function automatic logic [`PERIPH_ADDR_W-1:0] addr_for(input logic [2:0] sel);
        logic [`PERIPH_ADDR_W-1:0] a;
        a = `PERIPH_ADDR_W'($urandom);
        a[`REG_SEL_MSB:`REG_SEL_LSB] = sel;
        return a;
    endfunction

    task automatic send(input logic we, input logic [2:0] sel, input logic [31:0] wdata);
        req.en    = 1'b1;
        req.we    = we;
        req.addr  = addr_for(sel);
        req.wdata = wdata;
        @(posedge clk);
        #1;
        req = '0;
    endtask

    task automatic write_reg(input logic [2:0] sel, input logic [31:0] wdata);
        send(1'b1, sel, wdata);
        idle_cycles(WRITE_GAP);
    endtask

    task automatic read_reg(input logic [2:0] sel, output logic [31:0] value);
        send(1'b0, sel, '0);
        value = rdata;  // Valid in the cycle after the request
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
        input logic [31:0] act);
        check_count++;
        if (act !== exp)
        begin
            error_count++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_status(input string name, input logic [31:0] exp);
        logic [31:0] value;
        idle_cycles(SETTLE_CYCLES);
        read_reg(3'd3, value);
        check_value(name, exp, value);
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial
    begin : stimulus
        logic [31:0] value;
        logic [31:0] word;
        logic [2:0]  sel;
        logic [2:0]  unmapped [5];
        int          n_pops;

        void'($urandom(85597));
        unmapped    = '{3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        error_count = 0;
        check_count = 0;
        req         = '0;
        dip         = '0;
        rst         = 1'b1;
        model_reset();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // Reset state
        check_value("reset_leds", 32'(model_leds), 32'(leds));
        check_status("reset_status", expected_status(1'b0, 1'b1, 1'b0, 1'b0, 5'd0));

        // LEDs and DIP switches
        for (int i = 0; i < 8; i++)
        begin
            word = $urandom;
            write_reg(3'd0, word);
            model_leds = word[`LED_W-1:0];
            check_value($sformatf("leds_%0d", i), 32'(model_leds), 32'(leds));
            dip = `LED_W'($urandom);
            read_reg(3'd0, value);
            check_value($sformatf("dip_%0d", i), fixed_read(3'd0, dip), value);
        end

        // Random words in LFSR order
        write_reg(3'd3, 32'h1);
        model_en = 1'b1;
        check_status("fill_status", expected_status(1'b1, 1'b0, 1'b0, model_en, 5'd16));
        n_pops = 8 + ($urandom % 17);
        for (int i = 0; i < n_pops; i++)
        begin
            idle_cycles($urandom % 5);
            read_reg(3'd2, value);
            take_word(word);
            check_value($sformatf("rng_word_%0d", i), word, value);
            write_reg(3'd2, $urandom);  // Pop the head
        end
        check_status("refill_status", expected_status(1'b1, 1'b0, 1'b0, model_en, 5'd16));

        // Drain with generation off, then underflow
        write_reg(3'd3, 32'h0);
        model_en = 1'b0;
        for (int i = 0; i < `RNG_FIFO_DEPTH; i++)
        begin
            read_reg(3'd2, value);
            take_word(word);
            check_value($sformatf("drain_word_%0d", i), word, value);
            write_reg(3'd2, $urandom);
        end
        check_status("drained_status", expected_status(1'b0, 1'b1, 1'b0, 1'b0, 5'd0));
        write_reg(3'd2, $urandom);
        check_status("underflow_status", expected_status(1'b0, 1'b1, 1'b1, 1'b0, 5'd0));
        write_reg(3'd3, 32'h2);
        check_status("clear_status", expected_status(1'b0, 1'b1, 1'b0, 1'b0, 5'd0));

        // Unmapped selects
        for (int i = 0; i < 10; i++)
        begin
            sel = unmapped[$urandom % 5];
            read_reg(sel, value);
            check_value($sformatf("unmapped_sel%0d", sel), fixed_read(sel, dip), value);
        end

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("TEST PASS");
        end
        else
        begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
